//--- run_sim.sh
#!/bin/sh
# Build the SPWM testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f sim.f --top-module tb_spwm_top \
    -o sim_spwm || { echo "Build failed"; exit 1; }

out=$(./obj_dir/sim_spwm)
printf '%s\n' "$out"

printf '%s\n' "$out" | grep -q "^RESULT: PASS$" && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }

//--- sim.f
+incdir+verilog
verilog/spwm_types_pkg.sv
verilog/waveform_pkg.sv
verilog/table_stepper.sv
verilog/pwm_comparator.sv
verilog/dead_time_inserter.sv
verilog/spwm_top.sv
tb/tb_spwm_top.sv

//--- tb/tb_spwm_top.sv
`timescale 1ns/10ps

`include "spwm_params.svh"

module tb_spwm_top;

    localparam int DEAD          = `SPWM_DEAD_CYCLES;
    localparam int RESET_CYCLES  = 5;
    localparam int LATENCY_LIMIT = 40;
    localparam int T1_CYCLES     = RESET_CYCLES + LATENCY_LIMIT;
    localparam int T2_CYCLES     = 4 * 256;
    localparam int T3_CYCLES     = RESET_CYCLES + 4 * 256;
    localparam int T4_CYCLES     = RESET_CYCLES + 600 + 1 + 400;
    localparam int SEGMENTS      = 8;
    localparam int SEG_CYCLES    = 400;
    localparam int TOTAL_CYCLES  = T1_CYCLES + T2_CYCLES + T3_CYCLES + T4_CYCLES
                                   + SEGMENTS * SEG_CYCLES;
    localparam int MARGIN_CYCLES = 200;

    logic                        clk;
    logic                        rst;
    spwm_types_pkg::freq_cfg_t   freq;
    spwm_types_pkg::phase_bits_t pwm;
    spwm_types_pkg::gate_drive_t gates;

    // Reference model state
    spwm_types_pkg::period_word_t car_count;
    spwm_types_pkg::period_word_t sin_count;
    spwm_types_pkg::table_index_t car_index;
    spwm_types_pkg::table_index_t sin_index;
    spwm_types_pkg::phase_bits_t  exp_pwm;
    spwm_types_pkg::gate_drive_t  exp_gates;
    logic [2:0]                   dead_prev;
    int                           dead_count [3];

    // Observed pwm runs, for the short pulse check
    logic [2:0] run_value;
    int         run_length [3];

    spwm_top i_dut (
        .clk   (clk),
        .rst   (rst),
        .freq  (freq),
        .pwm   (pwm),
        .gates (gates)
    );

    always #10 clk = ~clk;

    ////////////////////////////////////////
    // Error reporting and compares
    ////////////////////////////////////////

    task automatic report_error(input string msg);
        $display("%s", msg);
        $display("RESULT: FAIL");
        $fatal(1, "Stopped at first error");
    endtask

    task automatic check_pwm(input string name, input spwm_types_pkg::phase_bits_t exp,
                             input spwm_types_pkg::phase_bits_t act);
        if (act !== exp) begin
            report_error($sformatf("FAILED %s: expected 0x%h, got 0x%h", name, exp, act));
        end
    endtask

    task automatic check_gates(input string name, input spwm_types_pkg::gate_drive_t exp,
                               input spwm_types_pkg::gate_drive_t act);
        if (act !== exp) begin
            report_error($sformatf("FAILED %s: expected 0x%h, got 0x%h", name, exp, act));
        end
    endtask

    task automatic check_index(input string name, input spwm_types_pkg::table_index_t exp,
                               input spwm_types_pkg::table_index_t act);
        if (act !== exp) begin
            report_error($sformatf("FAILED %s: expected 0x%h, got 0x%h", name, exp, act));
        end
    endtask

    task automatic check_count(input string name, input int exp, input int act);
        if (act != exp) begin
            report_error($sformatf("FAILED %s: expected 0x%h, got 0x%h", name, exp, act));
        end
    endtask

    ////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////

    // Triangle carrier, rising by two then falling from 255
    function automatic spwm_types_pkg::sample_t carrier_level(
        input spwm_types_pkg::table_index_t idx
    );
        int level;
        if (idx < 128) begin
            level = 2 * idx;
        end else begin
            level = 511 - 2 * idx;
        end
        return spwm_types_pkg::sample_t'(level);
    endfunction

    task automatic advance_model();
        spwm_types_pkg::sample_t carrier;
        spwm_types_pkg::table_index_t idx_b;
        spwm_types_pkg::table_index_t idx_c;
        logic [2:0] pwm_now;
        logic [2:0] hi_next;
        logic [2:0] lo_next;
        if (rst) begin
            car_count  = '0;
            sin_count  = '0;
            car_index  = '0;
            sin_index  = '0;
            exp_pwm    = '0;
            exp_gates  = '0;
            dead_prev  = '0;
            dead_count = '{default: 0};
        end else begin
            carrier = carrier_level(car_index);
            idx_b = spwm_types_pkg::table_index_t'(sin_index + `SPWM_PHASE_B_OFFSET);
            idx_c = spwm_types_pkg::table_index_t'(sin_index + `SPWM_PHASE_C_OFFSET);
            pwm_now = exp_pwm;
            // Dead time stage sees last cycle's pwm
            for (int i = 0; i < 3; i++) begin
                if (pwm_now[i] != dead_prev[i]) begin
                    dead_count[i] = 0;
                    hi_next[i] = 1'b0;
                    lo_next[i] = 1'b0;
                end else begin
                    hi_next[i] = pwm_now[i] && (dead_count[i] == DEAD);
                    lo_next[i] = !pwm_now[i] && (dead_count[i] == DEAD);
                    if (dead_count[i] < DEAD) begin
                        dead_count[i]++;
                    end
                end
            end
            dead_prev = pwm_now;
            exp_gates.hi = hi_next;
            exp_gates.lo = lo_next;
            exp_pwm.a = (waveform_pkg::sine_sample(sin_index) >= carrier);
            exp_pwm.b = (waveform_pkg::sine_sample(idx_b) >= carrier);
            exp_pwm.c = (waveform_pkg::sine_sample(idx_c) >= carrier);
            if (car_count >= freq.carrier_period) begin
                car_count = '0;
                car_index = car_index + 8'd1;
            end else begin
                car_count = car_count + 26'd1;
            end
            if (sin_count >= freq.sine_period) begin
                sin_count = '0;
                sin_index = sin_index + 8'd1;
            end else begin
                sin_count = sin_count + 26'd1;
            end
        end
    endtask

    task automatic check_gate_safety();
        logic [2:0] hi;
        logic [2:0] lo;
        logic [2:0] now;
        string leg;
        hi = gates.hi;
        lo = gates.lo;
        now = pwm;
        for (int i = 0; i < 3; i++) begin
            leg = (i == 2) ? "a" : ((i == 1) ? "b" : "c");
            if (hi[i] && lo[i]) begin
                report_error($sformatf("High and low gates of phase %s are on together", leg));
            end
            // A gate needs D+2 stable pwm samples behind it
            if ((hi[i] || lo[i]) && (run_value[i] != hi[i] || run_length[i] < DEAD + 2)) begin
                report_error($sformatf("Gate of phase %s turned on after a short pwm pulse",
                                       leg));
            end
            if (now[i] == run_value[i]) begin
                run_length[i]++;
            end else begin
                run_value[i] = now[i];
                run_length[i] = 1;
            end
        end
    endtask

    // One clock, model update and full compare
    task automatic step();
        @(posedge clk);
        #2;
        advance_model();
        check_pwm("pwm", exp_pwm, pwm);
        check_gates("gates", exp_gates, gates);
        check_index("carrier_index", car_index, i_dut.carrier_index);
        check_index("sine_index", sin_index, i_dut.sine_index);
        check_gate_safety();
    endtask

    task automatic apply_reset();
        rst = 1'b1;
        repeat (RESET_CYCLES) step();
        rst = 1'b0;
    endtask

    ////////////////////////////////////////
    // Tests
    ////////////////////////////////////////

    task automatic test_reset_state();
        int latency;
        // Indices hold at 0, so every leg compares high
        freq.sine_period = '1;
        freq.carrier_period = '1;
        rst = 1'b1;
        for (int i = 0; i < RESET_CYCLES; i++) begin
            step();
            check_pwm("pwm", '0, pwm);
            check_gates("gates", '0, gates);
        end
        rst = 1'b0;
        latency = 0;
        while (gates == '0 && latency < LATENCY_LIMIT) begin
            step();
            latency++;
        end
        // pwm edge after 1 clock, seen 1 clock later, then D+1
        check_count("gate latency", DEAD + 3, latency);
        check_pwm("gates.hi", 3'b111, gates.hi);
        check_pwm("gates.lo", 3'b000, gates.lo);
    endtask

    task automatic test_fixed_periods();
        freq.carrier_period = 26'd0;
        freq.sine_period = 26'd255;
        repeat (T2_CYCLES) step();
    endtask

    task automatic test_phase_offset();
        int dut_high [3];
        int exp_high [3];
        int offset [3];
        logic [2:0] seen;
        spwm_types_pkg::table_index_t car;
        spwm_types_pkg::table_index_t idx;
        dut_high = '{default: 0};
        exp_high = '{default: 0};
        offset = '{`SPWM_PHASE_C_OFFSET, `SPWM_PHASE_B_OFFSET, 0};
        freq.carrier_period = 26'd0;
        freq.sine_period = 26'd3;
        apply_reset();
        // 256 sine steps of 4 clocks
        // Sample n after reset holds sine index n/4 against carrier index n
        for (int n = 0; n < 4 * 256; n++) begin
            step();
            seen = pwm;
            car = spwm_types_pkg::table_index_t'(n);
            for (int i = 0; i < 3; i++) begin
                idx = spwm_types_pkg::table_index_t'(n / 4 + offset[i]);
                if (waveform_pkg::sine_sample(idx) >= carrier_level(car)) begin
                    exp_high[i]++;
                end
                if (seen[i]) begin
                    dut_high[i]++;
                end
            end
        end
        check_count("high cycles a", exp_high[2], dut_high[2]);
        check_count("high cycles b", exp_high[1], dut_high[1]);
        check_count("high cycles c", exp_high[0], dut_high[0]);
    endtask

    task automatic test_period_change();
        freq.carrier_period = 26'd1000;
        freq.sine_period = 26'd1000;
        apply_reset();
        repeat (600) step();
        check_index("carrier_index", 8'd0, i_dut.carrier_index);
        // Count is at 600, above both new words
        freq.carrier_period = 26'd100;
        freq.sine_period = 26'd50;
        step();
        check_index("carrier_index", 8'd1, i_dut.carrier_index);
        check_index("sine_index", 8'd1, i_dut.sine_index);
        // Wraps every 101 and every 51 clocks from here
        repeat (400) step();
        check_index("carrier_index", 8'd4, i_dut.carrier_index);
        check_index("sine_index", 8'd8, i_dut.sine_index);
    endtask

    task automatic test_random_dead_time();
        for (int s = 0; s < SEGMENTS; s++) begin
            freq.carrier_period = spwm_types_pkg::period_word_t'($urandom_range(0, 3));
            freq.sine_period = spwm_types_pkg::period_word_t'($urandom_range(0, 31));
            repeat (SEG_CYCLES) step();
        end
    endtask

    ////////////////////////////////////////
    // Run control
    ////////////////////////////////////////

    initial begin
        void'($urandom(32'hb3f0));
        clk = 1'b0;
        rst = 1'b1;
        freq = '0;
        run_value = '0;
        run_length = '{default: 0};
        test_reset_state();
        test_fixed_periods();
        test_phase_offset();
        test_period_change();
        test_random_dead_time();
        $display("RESULT: PASS");
        $finish;
    end

    initial begin
        #((TOTAL_CYCLES + MARGIN_CYCLES) * 20);
        $display("Simulation timed out after %0d cycles", TOTAL_CYCLES + MARGIN_CYCLES);
        $display("RESULT: FAIL");
        $fatal(1, "Watchdog expired");
    end

endmodule

//--- verilog/dead_time_inserter.sv
`timescale 1ns/10ps

`include "spwm_params.svh"

module dead_time_inserter #(
    parameter int DEAD_CYCLES = `SPWM_DEAD_CYCLES
) (
    input  logic clk,
    input  logic rst,
    input  logic pwm_in,
    output logic gate_hi,
    output logic gate_lo
);

    localparam int COUNT_BITS = $clog2(DEAD_CYCLES + 1);
    localparam logic [COUNT_BITS-1:0] DEAD_MAX = COUNT_BITS'(DEAD_CYCLES);

    logic                  pwm_prev;
    logic [COUNT_BITS-1:0] dead_count;
    logic                  pwm_edge;
    logic                  settled;

    assign pwm_edge = (pwm_in != pwm_prev);
    assign settled  = (dead_count == DEAD_MAX);

    ////////////////////////////////////////
    // Edge detect and dead counter
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            pwm_prev <= 1'b0;
        end else begin
            pwm_prev <= pwm_in;
        end
    end

    // Counts clocks since the last input edge, holds at the limit
    always_ff @(posedge clk) begin
        if (rst) begin
            dead_count <= '0;
        end else if (pwm_edge) begin
            dead_count <= '0;
        end else if (!settled) begin
            dead_count <= dead_count + 1'b1;
        end
    end

    ////////////////////////////////////////
    // Gate outputs
    ////////////////////////////////////////

    // Both gates drop on an edge, the new side waits out the dead interval
    always_ff @(posedge clk) begin
        if (rst) begin
            gate_hi <= 1'b0;
            gate_lo <= 1'b0;
        end else if (pwm_edge) begin
            gate_hi <= 1'b0;
            gate_lo <= 1'b0;
        end else begin
            gate_hi <= pwm_in && settled;
            gate_lo <= !pwm_in && settled;
        end
    end

endmodule

//--- verilog/pwm_comparator.sv
`timescale 1ns/10ps

`include "spwm_params.svh"

module pwm_comparator (
    input  logic                          clk,
    input  logic                          rst,
    input  spwm_types_pkg::table_index_t  carrier_index,
    input  spwm_types_pkg::table_index_t  sine_index,
    output spwm_types_pkg::phase_bits_t   pwm
);

    localparam spwm_types_pkg::table_index_t OFFSET_B =
        spwm_types_pkg::table_index_t'(`SPWM_PHASE_B_OFFSET);
    localparam spwm_types_pkg::table_index_t OFFSET_C =
        spwm_types_pkg::table_index_t'(`SPWM_PHASE_C_OFFSET);

    ////////////////////////////////////////
    // Phase indices and samples
    ////////////////////////////////////////

    spwm_types_pkg::table_index_t index_b;
    spwm_types_pkg::table_index_t index_c;

    spwm_types_pkg::sample_t carrier_value;
    spwm_types_pkg::sample_t sine_a_value;
    spwm_types_pkg::sample_t sine_b_value;
    spwm_types_pkg::sample_t sine_c_value;

    spwm_types_pkg::phase_bits_t compare;

    // Offsets wrap modulo the table depth
    assign index_b = sine_index + OFFSET_B;
    assign index_c = sine_index + OFFSET_C;

    always_comb begin
        carrier_value = waveform_pkg::triangle_sample(carrier_index);
        sine_a_value  = waveform_pkg::sine_sample(sine_index);
        sine_b_value  = waveform_pkg::sine_sample(index_b);
        sine_c_value  = waveform_pkg::sine_sample(index_c);
    end

    always_comb begin
        compare.a = (sine_a_value >= carrier_value);
        compare.b = (sine_b_value >= carrier_value);
        compare.c = (sine_c_value >= carrier_value);
    end

    ////////////////////////////////////////
    // Output register
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            pwm <= '0;
        end else begin
            pwm <= compare;
        end
    end

endmodule

//--- verilog/spwm_params.svh
`ifndef SPWM_PARAMS_SVH
`define SPWM_PARAMS_SVH

////////////////////////////////////////
// Waveform tables
////////////////////////////////////////

`define SPWM_SAMPLE_BITS 8
`define SPWM_TABLE_DEPTH 256

// Step period word, one clock per count
`define SPWM_FREQ_BITS 26

// Index offsets of phases B and C from phase A
`define SPWM_PHASE_B_OFFSET 85
`define SPWM_PHASE_C_OFFSET 170

// Gate blanking after each PWM edge, in clocks
`define SPWM_DEAD_CYCLES 4

`endif

//--- verilog/spwm_top.sv
`timescale 1ns/10ps

module spwm_top (
    input  logic                         clk,
    input  logic                         rst,
    input  spwm_types_pkg::freq_cfg_t    freq,
    output spwm_types_pkg::phase_bits_t  pwm,
    output spwm_types_pkg::gate_drive_t  gates
);

    spwm_types_pkg::table_index_t carrier_index;
    spwm_types_pkg::table_index_t sine_index;

    ////////////////////////////////////////
    // Waveform steppers
    ////////////////////////////////////////

    table_stepper carrier_stepper (
        .clk    (clk),
        .rst    (rst),
        .period (freq.carrier_period),
        .index  (carrier_index)
    );

    // Single sine stepper, phases B and C offset at lookup
    table_stepper sine_stepper (
        .clk    (clk),
        .rst    (rst),
        .period (freq.sine_period),
        .index  (sine_index)
    );

    ////////////////////////////////////////
    // Carrier compare
    ////////////////////////////////////////

    pwm_comparator comparator (
        .clk           (clk),
        .rst           (rst),
        .carrier_index (carrier_index),
        .sine_index    (sine_index),
        .pwm           (pwm)
    );

    ////////////////////////////////////////
    // Gate drive, one per leg
    ////////////////////////////////////////

    dead_time_inserter dead_a (
        .clk     (clk),
        .rst     (rst),
        .pwm_in  (pwm.a),
        .gate_hi (gates.hi.a),
        .gate_lo (gates.lo.a)
    );

    dead_time_inserter dead_b (
        .clk     (clk),
        .rst     (rst),
        .pwm_in  (pwm.b),
        .gate_hi (gates.hi.b),
        .gate_lo (gates.lo.b)
    );

    dead_time_inserter dead_c (
        .clk     (clk),
        .rst     (rst),
        .pwm_in  (pwm.c),
        .gate_hi (gates.hi.c),
        .gate_lo (gates.lo.c)
    );

endmodule

//--- verilog/spwm_types_pkg.sv
`include "spwm_params.svh"

package spwm_types_pkg;

    localparam int INDEX_BITS = $clog2(`SPWM_TABLE_DEPTH);

    // Waveform amplitude
    typedef logic [`SPWM_SAMPLE_BITS-1:0] sample_t;

    // Table position, wraps at the table depth
    typedef logic [INDEX_BITS-1:0] table_index_t;

    // Index advances once every period+1 clocks
    typedef logic [`SPWM_FREQ_BITS-1:0] period_word_t;

    ////////////////////////////////////////
    // Bundles
    ////////////////////////////////////////

    typedef struct packed {
        period_word_t sine_period;
        period_word_t carrier_period;
    } freq_cfg_t;

    // One bit per inverter leg
    typedef struct packed {
        logic a;
        logic b;
        logic c;
    } phase_bits_t;

    typedef struct packed {
        phase_bits_t hi;
        phase_bits_t lo;
    } gate_drive_t;

endpackage

//--- verilog/table_stepper.sv
`timescale 1ns/10ps

module table_stepper (
    input  logic                          clk,
    input  logic                          rst,
    input  spwm_types_pkg::period_word_t  period,
    output spwm_types_pkg::table_index_t  index
);

    ////////////////////////////////////////
    // Period counter
    ////////////////////////////////////////

    spwm_types_pkg::period_word_t count;
    logic                         wrap;

    // Compare against the live word so a lowered period wraps at once
    assign wrap = (count >= period);

    always_ff @(posedge clk) begin
        if (rst) begin
            count <= '0;
        end else if (wrap) begin
            count <= '0;
        end else begin
            count <= count + 1'b1;
        end
    end

    ////////////////////////////////////////
    // Table index
    ////////////////////////////////////////

    // Natural rollover at the table depth
    always_ff @(posedge clk) begin
        if (rst) begin
            index <= '0;
        end else if (wrap) begin
            index <= index + 1'b1;
        end
    end

endmodule

//--- verilog/waveform_pkg.sv
package waveform_pkg;

    // One full sine period, centred on mid scale
    localparam spwm_types_pkg::sample_t SINE_TABLE [0:255] = '{
        128, 131, 134, 137, 140, 143, 146, 149,
        152, 155, 158, 162, 165, 167, 170, 173,
        176, 179, 182, 185, 188, 190, 193, 196,
        198, 201, 203, 206, 208, 211, 213, 215,
        218, 220, 222, 224, 226, 228, 230, 232,
        234, 235, 237, 238, 240, 241, 243, 244,
        245, 246, 248, 249, 250, 250, 251, 252,
        253, 253, 254, 254, 254, 255, 255, 255,
        255, 255, 255, 255, 254, 254, 254, 253,
        253, 252, 251, 250, 250, 249, 248, 246,
        245, 244, 243, 241, 240, 238, 237, 235,
        234, 232, 230, 228, 226, 224, 222, 220,
        218, 215, 213, 211, 208, 206, 203, 201,
        198, 196, 193, 190, 188, 185, 182, 179,
        176, 173, 170, 167, 165, 162, 158, 155,
        152, 149, 146, 143, 140, 137, 134, 131,
        128, 124, 121, 118, 115, 112, 109, 106,
        103, 100,  97,  93,  90,  88,  85,  82,
         79,  76,  73,  70,  67,  65,  62,  59,
         57,  54,  52,  49,  47,  44,  42,  40,
         37,  35,  33,  31,  29,  27,  25,  23,
         21,  20,  18,  17,  15,  14,  12,  11,
         10,   9,   7,   6,   5,   5,   4,   3,
          2,   2,   1,   1,   1,   0,   0,   0,
          0,   0,   0,   0,   1,   1,   1,   2,
          2,   3,   4,   5,   5,   6,   7,   9,
         10,  11,  12,  14,  15,  17,  18,  20,
         21,  23,  25,  27,  29,  31,  33,  35,
         37,  40,  42,  44,  47,  49,  52,  54,
         57,  59,  62,  65,  67,  70,  73,  76,
         79,  82,  85,  88,  90,  93,  97, 100,
        103, 106, 109, 112, 115, 118, 121, 124
    };

    function automatic spwm_types_pkg::sample_t sine_sample(
        input spwm_types_pkg::table_index_t idx
    );
        return SINE_TABLE[idx];
    endfunction

    ////////////////////////////////////////
    // Triangle carrier
    ////////////////////////////////////////

    // Rises 0..254 over the first half, falls 255..1 over the second
    function automatic spwm_types_pkg::sample_t triangle_sample(
        input spwm_types_pkg::table_index_t idx
    );
        logic [8:0] doubled;
        logic [8:0] falling;
        doubled = {idx, 1'b0};
        falling = 9'd511 - doubled;
        if (idx[7] == 1'b0) begin
            return doubled[7:0];
        end
        return falling[7:0];
    endfunction

endpackage
